//--- controlPkg.sv
`default_nettype none

package controlPkg;

	// Instruction fields
	typedef enum logic [5:0] {
		rType = 6'b000000,
		addi  = 6'b001000,
		addiu = 6'b001001,
		lui   = 6'b001111
	} opcodeT;

	typedef enum logic [5:0] {
		add    = 6'b100000,
		sub    = 6'b100010,
		bitAnd = 6'b100100,
		srl    = 6'b000010,
		sra    = 6'b000011,
		xchg   = 6'b000101,
		brk    = 6'b001101
	} functT;

	typedef enum logic [3:0] {
		classAddImm,
		classLui,
		classAdd,
		classSub,
		classAnd,
		classSrl,
		classSra,
		classXchg,
		classBreak,
		classUnsupported
	} instrClassT;

	// FSM steps
	typedef enum logic [6:0] {
		fetch       = 7'd0,
		waitFetch   = 7'd1,
		waitFetch2  = 7'd2,
		decode      = 7'd3,
		execute     = 7'd4,
		addImmWrite = 7'd5,
		aluWrite    = 7'd6,
		shiftWrite  = 7'd7,
		xchgWrite   = 7'd8,
		waitStep    = 7'd127
	} stepT;

	// Datapath select fields
	typedef enum logic [2:0] {
		pcKeep      = 3'd0,
		pcAluResult = 3'd1
	} pcSourceT;

	typedef enum logic [1:0] {
		srcAPc   = 2'd0,
		srcARegA = 2'd2
	} aluSrcAT;

	typedef enum logic [2:0] {
		srcBRegB         = 3'd0,
		srcBFour         = 3'd1,
		srcBImm          = 3'd2,
		srcBBranchOffset = 3'd4
	} aluSrcBT;

	typedef enum logic [2:0] {
		aluNone = 3'd0,
		aluAdd  = 3'd1,
		aluSub  = 3'd2,
		aluAnd  = 3'd3
	} aluOpT;

	typedef enum logic [2:0] {
		shiftNone       = 3'd0,
		shiftLoad       = 3'd1,
		shiftRight      = 3'd3,
		shiftRightArith = 3'd4
	} shiftCtrlT;

	typedef enum logic [2:0] {
		dstNone  = 3'd0,
		dstRt    = 3'd1,
		dstRtLui = 3'd2,
		dstRd    = 3'd5
	} regDstT;

	// Register file write-back source
	typedef enum logic [3:0] {
		wbRegA      = 4'd0,
		wbShift     = 4'd3,
		wbAluOut    = 4'd8,
		wbLuiImm    = 4'd10,
		wbStackInit = 4'd11
	} wbSrcT;

	typedef struct packed {
		logic      pcWrite;
		pcSourceT  pcSource;
		logic      irWrite;
		logic      writeRegA;
		logic      writeRegB;
		aluSrcAT   aluSrcA;
		aluSrcBT   aluSrcB;
		aluOpT     aluOp;
		logic      aluOutWrite;
		shiftCtrlT shiftCtrl;
		logic      shiftSrc;
		logic      shiftAmt;
		regDstT    regDst;
		wbSrcT     wbSrc;
		logic      regWrite;
	} controlWordT;

	localparam controlWordT idleWord = '{
		pcWrite:     1'b0,
		pcSource:    pcKeep,
		irWrite:     1'b0,
		writeRegA:   1'b0,
		writeRegB:   1'b0,
		aluSrcA:     srcAPc,
		aluSrcB:     srcBRegB,
		aluOp:       aluNone,
		aluOutWrite: 1'b0,
		shiftCtrl:   shiftNone,
		shiftSrc:    1'b0,
		shiftAmt:    1'b0,
		regDst:      dstNone,
		wbSrc:       wbRegA,
		regWrite:    1'b0
	};

	// Loads the stack pointer initial value while reset is held
	localparam controlWordT resetWord = '{
		pcWrite:     1'b0,
		pcSource:    pcKeep,
		irWrite:     1'b0,
		writeRegA:   1'b0,
		writeRegB:   1'b0,
		aluSrcA:     srcAPc,
		aluSrcB:     srcBRegB,
		aluOp:       aluNone,
		aluOutWrite: 1'b0,
		shiftCtrl:   shiftNone,
		shiftSrc:    1'b0,
		shiftAmt:    1'b0,
		regDst:      dstRd,
		wbSrc:       wbStackInit,
		regWrite:    1'b1
	};

endpackage

`default_nettype wire

//--- controlUnit.sv
`default_nettype none

module controlUnit (
	input wire clock,
	input wire reset,
	input var controlPkg::opcodeT opcode,
	input var controlPkg::functT funct,
	output controlPkg::controlWordT control,
	output controlPkg::stepT step
);

	controlPkg::instrClassT instrClass;

	instrDecoder instrDecoder_i (
		.opcode(opcode),
		.funct(funct),
		.instrClass(instrClass)
	);

	stepSequencer stepSequencer_i (
		.clock(clock),
		.reset(reset),
		.instrClass(instrClass),
		.control(control),
		.step(step)
	);

endmodule

`default_nettype wire

//--- controlUnitTbCases.svh
`ifndef CONTROL_UNIT_TB_CASES_SVH
`define CONTROL_UNIT_TB_CASES_SVH

// Raw opcode and funct bits, execute word, step after execute,
// write-step word, cycles from fetch back to fetch
typedef struct packed {
	logic [5:0] opcodeBits;
	logic [5:0] functBits;
	controlPkg::controlWordT execWord;
	controlPkg::stepT afterExec;
	controlPkg::controlWordT writeWord;
	logic [3:0] cycles;
} caseRowT;

localparam int caseCount = 16;

caseRowT caseTable [caseCount];

// PC update through the ALU with the constant four
function automatic controlPkg::controlWordT pcStepWord(input controlPkg::aluOpT op);
	controlPkg::controlWordT w;
	w = controlPkg::idleWord;
	w.pcWrite = 1'b1;
	w.pcSource = controlPkg::pcAluResult;
	w.aluSrcB = controlPkg::srcBFour;
	w.aluOp = op;
	return w;
endfunction

function automatic controlPkg::controlWordT aluExecWord(
	input controlPkg::aluSrcBT srcB,
	input controlPkg::aluOpT op
);
	controlPkg::controlWordT w;
	w = controlPkg::idleWord;
	w.aluSrcA = controlPkg::srcARegA;
	w.aluSrcB = srcB;
	w.aluOp = op;
	w.aluOutWrite = 1'b1;
	return w;
endfunction

function automatic controlPkg::controlWordT shiftExecWord(input controlPkg::shiftCtrlT mode);
	controlPkg::controlWordT w;
	w = controlPkg::idleWord;
	w.shiftAmt = 1'b1;
	w.shiftCtrl = mode;
	return w;
endfunction

function automatic controlPkg::controlWordT regWriteWord(
	input controlPkg::regDstT dst,
	input controlPkg::wbSrcT src
);
	controlPkg::controlWordT w;
	w = controlPkg::idleWord;
	w.regWrite = 1'b1;
	w.regDst = dst;
	w.wbSrc = src;
	return w;
endfunction

function automatic caseRowT makeRow(
	input logic [5:0] opcodeBits,
	input logic [5:0] functBits,
	input controlPkg::controlWordT execWord,
	input controlPkg::stepT afterExec,
	input controlPkg::controlWordT writeWord,
	input logic [3:0] cycles
);
	return '{opcodeBits, functBits, execWord, afterExec, writeWord, cycles};
endfunction

task automatic fillCases();
	controlPkg::controlWordT aluDone;
	aluDone = regWriteWord(controlPkg::dstRd, controlPkg::wbAluOut);
	// funct is ignored outside R-type
	caseTable[0] = makeRow(6'h08, 6'h0d, aluExecWord(controlPkg::srcBImm, controlPkg::aluAdd),
		controlPkg::addImmWrite, regWriteWord(controlPkg::dstRt, controlPkg::wbAluOut), 4'd7);
	caseTable[1] = makeRow(6'h09, 6'h2a, aluExecWord(controlPkg::srcBImm, controlPkg::aluAdd),
		controlPkg::addImmWrite, regWriteWord(controlPkg::dstRt, controlPkg::wbAluOut), 4'd7);
	caseTable[2] = makeRow(6'h00, 6'h20, aluExecWord(controlPkg::srcBRegB, controlPkg::aluAdd),
		controlPkg::aluWrite, aluDone, 4'd7);
	caseTable[3] = makeRow(6'h00, 6'h22, aluExecWord(controlPkg::srcBRegB, controlPkg::aluSub),
		controlPkg::aluWrite, aluDone, 4'd7);
	caseTable[4] = makeRow(6'h00, 6'h24, aluExecWord(controlPkg::srcBRegB, controlPkg::aluAnd),
		controlPkg::aluWrite, aluDone, 4'd7);
	caseTable[5] = makeRow(6'h00, 6'h02, shiftExecWord(controlPkg::shiftRight),
		controlPkg::shiftWrite, regWriteWord(controlPkg::dstRd, controlPkg::wbShift), 4'd7);
	caseTable[6] = makeRow(6'h00, 6'h03, shiftExecWord(controlPkg::shiftRightArith),
		controlPkg::shiftWrite, regWriteWord(controlPkg::dstRd, controlPkg::wbShift), 4'd7);
	caseTable[7] = makeRow(6'h00, 6'h05, controlPkg::idleWord,
		controlPkg::xchgWrite, regWriteWord(controlPkg::dstRd, controlPkg::wbRegA), 4'd7);
	caseTable[8] = makeRow(6'h0f, 6'h00, regWriteWord(controlPkg::dstRtLui, controlPkg::wbLuiImm),
		controlPkg::waitStep, controlPkg::idleWord, 4'd6);
	caseTable[9] = makeRow(6'h0f, 6'h20, regWriteWord(controlPkg::dstRtLui, controlPkg::wbLuiImm),
		controlPkg::waitStep, controlPkg::idleWord, 4'd6);
	caseTable[10] = makeRow(6'h00, 6'h0d, pcStepWord(controlPkg::aluSub),
		controlPkg::fetch, controlPkg::idleWord, 4'd5);
	// Unsupported opcodes, then unsupported R-type function codes
	caseTable[11] = makeRow(6'h23, 6'h00, controlPkg::idleWord,
		controlPkg::waitStep, controlPkg::idleWord, 4'd6);
	caseTable[12] = makeRow(6'h04, 6'h20, controlPkg::idleWord,
		controlPkg::waitStep, controlPkg::idleWord, 4'd6);
	caseTable[13] = makeRow(6'h3f, 6'h3f, controlPkg::idleWord,
		controlPkg::waitStep, controlPkg::idleWord, 4'd6);
	caseTable[14] = makeRow(6'h00, 6'h2a, controlPkg::idleWord,
		controlPkg::waitStep, controlPkg::idleWord, 4'd6);
	caseTable[15] = makeRow(6'h00, 6'h00, controlPkg::idleWord,
		controlPkg::waitStep, controlPkg::idleWord, 4'd6);
endtask

`endif

//--- controlUnitTb.sv
`default_nettype none

module controlUnitTb;

	timeunit 1ns;
	timeprecision 100ps;

	`include "controlUnitTbCases.svh"

	localparam int clockPeriod = 20;

	typedef struct packed {
		controlPkg::controlWordT word;
		controlPkg::stepT step;
	} expectT;

	logic clock;
	logic reset;
	controlPkg::opcodeT opcode;
	controlPkg::functT funct;
	controlPkg::controlWordT control;
	controlPkg::stepT step;

	controlUnit controlUnit_i (
		.clock(clock),
		.reset(reset),
		.opcode(opcode),
		.funct(funct),
		.control(control),
		.step(step)
	);

	initial begin
		clock = 1'b0;
		forever begin
			#(clockPeriod / 2);
			clock = ~clock;
		end
	end

	// Budget of 8 cycles per row plus reset and recovery
	initial begin
		#((caseCount * 8 + 40) * clockPeriod);
		$display("Timeout: the run did not finish within the cycle budget");
		$display(">>> FAIL");
		$fatal(1, "watchdog expired");
	end

	// Outputs settle well before inputs change again
	task automatic nextCycle();
		@(posedge clock);
		#2;
	endtask

	task automatic checkOutputs(
		input controlPkg::controlWordT expWord,
		input controlPkg::stepT expStep,
		input string what
	);
		assert (control === expWord) else begin
			$display("CHECK FAILED at %0t ns: %s control is %h, expected %h",
				$time, what, control, expWord);
			$display(">>> FAIL");
			$fatal(1, "control word mismatch");
		end
		assert (step === expStep) else begin
			$display("CHECK FAILED at %0t ns: %s step is %0d, expected %0d",
				$time, what, step, expStep);
			$display(">>> FAIL");
			$fatal(1, "step mismatch");
		end
	endtask

	// Control lags step, so cycle n shows the word of the step before
	function automatic expectT expectedAt(input caseRowT row, input int n);
		expectT e;
		controlPkg::controlWordT decodeWord;
		decodeWord = controlPkg::idleWord;
		decodeWord.writeRegA = 1'b1;
		decodeWord.writeRegB = 1'b1;
		decodeWord.aluSrcB = controlPkg::srcBBranchOffset;
		decodeWord.aluOp = controlPkg::aluAdd;
		decodeWord.aluOutWrite = 1'b1;
		decodeWord.shiftCtrl = controlPkg::shiftLoad;
		decodeWord.shiftSrc = 1'b1;
		e.word = controlPkg::idleWord;
		e.step = controlPkg::fetch;
		case (n)
			1: e = '{pcStepWord(controlPkg::aluAdd), controlPkg::waitFetch};
			2: e = '{controlPkg::idleWord, controlPkg::waitFetch2};
			3: begin
				e.word.irWrite = 1'b1;
				e.step = controlPkg::decode;
			end
			4: e = '{decodeWord, controlPkg::execute};
			5: e = '{row.execWord, row.afterExec};
			6: begin
				if (row.cycles == 4'd7) begin
					e = '{row.writeWord, controlPkg::waitStep};
				end else begin
					e = '{controlPkg::idleWord, controlPkg::fetch};
				end
			end
			default: e = '{controlPkg::idleWord, controlPkg::fetch};
		endcase
		return e;
	endfunction

	task automatic runCase(input caseRowT row, input int index, input int limit);
		expectT e;
		int n;
		opcode = controlPkg::opcodeT'(row.opcodeBits);
		funct = controlPkg::functT'(row.functBits);
		n = 0;
		do begin
			nextCycle();
			n++;
			e = expectedAt(row, n);
			checkOutputs(e.word, e.step, $sformatf("case %0d cycle %0d", index, n));
		end while (step != controlPkg::fetch && n < limit);
		assert (n == int'(row.cycles)) else begin
			$display("CHECK FAILED at %0t ns: case %0d took %0d cycles, expected %0d",
				$time, index, n, row.cycles);
			$display(">>> FAIL");
			$fatal(1, "cycle count mismatch");
		end
	endtask

	initial begin
		int order [caseCount];
		int pick;
		int held;
		controlPkg::controlWordT resetExp;
		expectT midExp;
		void'($urandom(43));
		reset = 1'b1;
		opcode = controlPkg::rType;
		funct = controlPkg::add;
		fillCases();
		resetExp = regWriteWord(controlPkg::dstRd, controlPkg::wbStackInit);
		for (int i = 0; i < caseCount; i++) begin
			order[i] = i;
		end
		for (int i = caseCount - 1; i > 0; i--) begin
			pick = int'($urandom % (i + 1));
			held = order[i];
			order[i] = order[pick];
			order[pick] = held;
		end

		repeat (8) begin
			nextCycle();
			checkOutputs(resetExp, controlPkg::fetch, "reset");
		end
		reset = 1'b0;
		#1;
		checkOutputs(resetExp, controlPkg::fetch, "after reset release");

		for (int k = 0; k < caseCount; k++) begin
			runCase(caseTable[order[k]], order[k], 8);
		end

		// Reset in the middle of a SUB, then one clean ADDI
		opcode = controlPkg::rType;
		funct = controlPkg::sub;
		for (int n = 1; n <= 3; n++) begin
			nextCycle();
			midExp = expectedAt(caseTable[3], n);
			checkOutputs(midExp.word, midExp.step, $sformatf("interrupted cycle %0d", n));
		end
		reset = 1'b1;
		nextCycle();
		checkOutputs(resetExp, controlPkg::fetch, "reset mid-instruction");
		reset = 1'b0;
		runCase(caseTable[0], 0, 8);

		$display(">>> PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- controlWordTable.sv
`default_nettype none

module controlWordTable (
	input var controlPkg::stepT currentStep,
	input var controlPkg::instrClassT instrClass,
	output controlPkg::controlWordT word
);

	always_comb begin
		word = controlPkg::idleWord;
		case (currentStep)
			// PC + 4 while memory reads the instruction
			controlPkg::fetch: begin
				word.pcWrite = 1'b1;
				word.pcSource = controlPkg::pcAluResult;
				word.aluSrcB = controlPkg::srcBFour;
				word.aluOp = controlPkg::aluAdd;
			end
			controlPkg::waitFetch2: begin
				word.irWrite = 1'b1;
			end
			// Operand fetch and speculative branch target
			controlPkg::decode: begin
				word.writeRegA = 1'b1;
				word.writeRegB = 1'b1;
				word.aluSrcB = controlPkg::srcBBranchOffset;
				word.aluOp = controlPkg::aluAdd;
				word.aluOutWrite = 1'b1;
				word.shiftCtrl = controlPkg::shiftLoad;
				word.shiftSrc = 1'b1;
			end
			controlPkg::execute: begin
				case (instrClass)
					controlPkg::classAddImm: begin
						word.aluSrcA = controlPkg::srcARegA;
						word.aluSrcB = controlPkg::srcBImm;
						word.aluOp = controlPkg::aluAdd;
						word.aluOutWrite = 1'b1;
					end
					controlPkg::classAdd: begin
						word.aluSrcA = controlPkg::srcARegA;
						word.aluSrcB = controlPkg::srcBRegB;
						word.aluOp = controlPkg::aluAdd;
						word.aluOutWrite = 1'b1;
					end
					controlPkg::classSub: begin
						word.aluSrcA = controlPkg::srcARegA;
						word.aluSrcB = controlPkg::srcBRegB;
						word.aluOp = controlPkg::aluSub;
						word.aluOutWrite = 1'b1;
					end
					controlPkg::classAnd: begin
						word.aluSrcA = controlPkg::srcARegA;
						word.aluSrcB = controlPkg::srcBRegB;
						word.aluOp = controlPkg::aluAnd;
						word.aluOutWrite = 1'b1;
					end
					// Shift amount comes from the shamt field
					controlPkg::classSrl: begin
						word.shiftAmt = 1'b1;
						word.shiftCtrl = controlPkg::shiftRight;
					end
					controlPkg::classSra: begin
						word.shiftAmt = 1'b1;
						word.shiftCtrl = controlPkg::shiftRightArith;
					end
					controlPkg::classLui: begin
						word.regWrite = 1'b1;
						word.regDst = controlPkg::dstRtLui;
						word.wbSrc = controlPkg::wbLuiImm;
					end
					// Undo the fetch increment so the PC stays on the break
					controlPkg::classBreak: begin
						word.pcWrite = 1'b1;
						word.pcSource = controlPkg::pcAluResult;
						word.aluSrcB = controlPkg::srcBFour;
						word.aluOp = controlPkg::aluSub;
					end
					default: begin
						word = controlPkg::idleWord;
					end
				endcase
			end
			controlPkg::addImmWrite: begin
				word.regWrite = 1'b1;
				word.regDst = controlPkg::dstRt;
				word.wbSrc = controlPkg::wbAluOut;
			end
			controlPkg::aluWrite: begin
				word.regWrite = 1'b1;
				word.regDst = controlPkg::dstRd;
				word.wbSrc = controlPkg::wbAluOut;
			end
			controlPkg::shiftWrite: begin
				word.regWrite = 1'b1;
				word.regDst = controlPkg::dstRd;
				word.wbSrc = controlPkg::wbShift;
			end
			// Register A value lands in rd
			controlPkg::xchgWrite: begin
				word.regWrite = 1'b1;
				word.regDst = controlPkg::dstRd;
				word.wbSrc = controlPkg::wbRegA;
			end
			default: begin
				word = controlPkg::idleWord;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- files.f
+incdir+.
controlPkg.sv
instrDecoder.sv
controlWordTable.sv
stepSequencer.sv
controlUnit.sv
controlUnitTb.sv

//--- instrDecoder.sv
`default_nettype none

module instrDecoder (
	input var controlPkg::opcodeT opcode,
	input var controlPkg::functT funct,
	output controlPkg::instrClassT instrClass
);

	always_comb begin
		instrClass = controlPkg::classUnsupported;
		case (opcode)
			// Signed and unsigned add immediate share one datapath sequence
			controlPkg::addi,
			controlPkg::addiu: begin
				instrClass = controlPkg::classAddImm;
			end
			controlPkg::lui: begin
				instrClass = controlPkg::classLui;
			end
			controlPkg::rType: begin
				case (funct)
					controlPkg::add: begin
						instrClass = controlPkg::classAdd;
					end
					controlPkg::sub: begin
						instrClass = controlPkg::classSub;
					end
					controlPkg::bitAnd: begin
						instrClass = controlPkg::classAnd;
					end
					controlPkg::srl: begin
						instrClass = controlPkg::classSrl;
					end
					controlPkg::sra: begin
						instrClass = controlPkg::classSra;
					end
					controlPkg::xchg: begin
						instrClass = controlPkg::classXchg;
					end
					controlPkg::brk: begin
						instrClass = controlPkg::classBreak;
					end
					default: begin
						instrClass = controlPkg::classUnsupported;
					end
				endcase
			end
			default: begin
				instrClass = controlPkg::classUnsupported;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module controlUnitTb -f files.f -o controlUnitSim

output=$(./obj_dir/controlUnitSim 2>&1) || true
echo "$output"

if echo "$output" | grep -qxF '>>> PASS'; then
	exit 0
fi
exit 1

//--- stepSequencer.sv
`default_nettype none

module stepSequencer (
	input wire clock,
	input wire reset,
	input var controlPkg::instrClassT instrClass,
	output controlPkg::controlWordT control,
	output controlPkg::stepT step
);

	controlPkg::controlWordT tableWord;
	controlPkg::stepT nextStep;

	controlWordTable controlWordTable_i (
		.currentStep(step),
		.instrClass(instrClass),
		.word(tableWord)
	);

	always_comb begin
		nextStep = controlPkg::fetch;
		case (step)
			controlPkg::fetch: begin
				nextStep = controlPkg::waitFetch;
			end
			controlPkg::waitFetch: begin
				nextStep = controlPkg::waitFetch2;
			end
			controlPkg::waitFetch2: begin
				nextStep = controlPkg::decode;
			end
			controlPkg::decode: begin
				nextStep = controlPkg::execute;
			end
			// Class is only looked at here
			controlPkg::execute: begin
				case (instrClass)
					controlPkg::classAddImm: begin
						nextStep = controlPkg::addImmWrite;
					end
					controlPkg::classAdd,
					controlPkg::classSub,
					controlPkg::classAnd: begin
						nextStep = controlPkg::aluWrite;
					end
					controlPkg::classSrl,
					controlPkg::classSra: begin
						nextStep = controlPkg::shiftWrite;
					end
					controlPkg::classXchg: begin
						nextStep = controlPkg::xchgWrite;
					end
					controlPkg::classBreak: begin
						nextStep = controlPkg::fetch;
					end
					default: begin
						nextStep = controlPkg::waitStep;
					end
				endcase
			end
			controlPkg::addImmWrite,
			controlPkg::aluWrite,
			controlPkg::shiftWrite,
			controlPkg::xchgWrite: begin
				nextStep = controlPkg::waitStep;
			end
			default: begin
				nextStep = controlPkg::fetch;
			end
		endcase
	end

	// Word and step move together, so control lags step by one
	always_ff @(posedge clock) begin
		if (reset) begin
			control <= controlPkg::resetWord;
			step <= controlPkg::fetch;
		end else begin
			control <= tableWord;
			step <= nextStep;
		end
	end

endmodule

`default_nettype wire
